// File: design/ib_pkg.sv
// ------------------------------------------------------------
// shared types and constants for the decode instruction buffer
// depth is fixed at 4; no other buffer depth is supported
// debug memory commands are not handled by this block
// ------------------------------------------------------------
package ib_pkg;

   localparam int ib_depth = 4;   // buffer slots, slot 0 is oldest
   localparam int xlen     = 32;  // instruction width
   localparam int pc_w     = 31;  // pc bits 31:1
   localparam int csr_w    = 12;
   localparam int gpr_w    = 5;

   // debug command types
   localparam logic [1:0] dbg_type_gpr = 2'h0;
   localparam logic [1:0] dbg_type_csr = 2'h1;
   localparam logic [1:0] dbg_type_mem = 2'h2;

   // csr used only in debug mode, a write here is a fence
   localparam logic [csr_w-1:0] csr_dbg_fence = 12'h7c4;

   // opcodes and funct3 values of the synthesized words
   localparam logic [6:0] op_or     = 7'b0110011;
   localparam logic [6:0] op_system = 7'b1110011;
   localparam logic [2:0] f3_or     = 3'b110;
   localparam logic [2:0] f3_csrrs  = 3'b010;
   localparam logic [2:0] f3_csrrw  = 3'b001;

   typedef struct packed {
      logic icaf;          // access fault
      logic icaf_second;   // fault on upper 2B of a 4B inst
      logic perr;          // parity error
      logic sbecc;         // single-bit ecc
      logic dbecc;         // double-bit ecc
   } ib_fault_t;

   // one buffer entry, 69 bits
   typedef struct packed {
      logic [xlen-1:0] instr;
      logic [pc_w-1:0] pc;     // pc[31:1]
      logic            pc4;    // 4B inst, else 2B
      ib_fault_t       fault;
   } ib_entry_t;

   // debug address read either as a gpr index or a csr address
   typedef union packed {
      struct packed {
         logic [csr_w-gpr_w-1:0] rsvd;
         logic [gpr_w-1:0]       idx;
      } gpr;
      logic [csr_w-1:0] csr;
   } dbg_addr_u;

   typedef struct packed {
      logic       valid;
      logic       write;
      logic [1:0] cmd_type;
      dbg_addr_u  addr;
   } dbg_cmd_t;

   // slot write and shift selects, 13 bits
   typedef struct packed {
      logic [ib_depth-1:0] i0_wen;   // lane 0 writes slot k
      logic [ib_depth-1:1] i1_wen;   // lane 1 never lands in slot 0
      logic                sh_1_0;
      logic                sh_2_1;
      logic                sh_3_2;
      logic                sh_2_0;
      logic                sh_3_1;
      logic                dbg_0;    // slot 0 takes the debug word
   } ib_wsel_t;

endpackage

// File: design/ib_dbg_synth.sv
// ------------------------------------------------------------
// debug gpr/csr command to instruction word translation
// core is halted, so the write data is consumed next cycle
// ------------------------------------------------------------
`timescale 1ns/1ps

module ib_dbg_synth
   import ib_pkg::*;
(
   input  logic            clk,
   input  logic            rst_n,
   input  dbg_cmd_t        dbg_cmd,
   output logic            dbg_take,
   output logic [xlen-1:0] dbg_instr,
   output logic            dbg_wdata_rs1,
   output logic            dbg_fence
);

   logic is_gpr;
   logic is_csr;
   logic wr_take;
   logic fence_in;

   // memory commands go elsewhere
   assign dbg_take = dbg_cmd.valid & (dbg_cmd.cmd_type != dbg_type_mem);

   assign is_gpr  = dbg_cmd.cmd_type == dbg_type_gpr;
   assign is_csr  = dbg_cmd.cmd_type == dbg_type_csr;
   assign wr_take = dbg_take & dbg_cmd.write & (is_gpr | is_csr);

   always_comb begin
      dbg_instr = '0;
      if (dbg_take && is_gpr) begin
         if (dbg_cmd.write) begin
            // or reg, x0, x0 with the write data on rs1
            dbg_instr = {17'b0, f3_or, dbg_cmd.addr.gpr.idx, op_or};
         end else begin
            // or x0, reg, x0 puts the register on rs1
            dbg_instr = {12'b0, dbg_cmd.addr.gpr.idx, f3_or, 5'b0, op_or};
         end
      end else if (dbg_take && is_csr) begin
         if (dbg_cmd.write) begin
            dbg_instr = {dbg_cmd.addr.csr, 5'b0, f3_csrrw, 5'b0, op_system};   // csrrw
         end else begin
            dbg_instr = {dbg_cmd.addr.csr, 5'b0, f3_csrrs, 5'b0, op_system};   // csrrs
         end
      end
   end

   assign fence_in = wr_take & is_csr & (dbg_cmd.addr.csr == csr_dbg_fence);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dbg_wdata_rs1 <= 1'b0;
         dbg_fence     <= 1'b0;
      end else begin
         dbg_wdata_rs1 <= wr_take;
         dbg_fence     <= fence_in;
      end
   end

   // an undefined type would be taken with an all-zero word
   a_cmd_type: assert property (@(posedge clk) disable iff (!rst_n)
      dbg_cmd.valid |-> (is_gpr || is_csr || dbg_cmd.cmd_type == dbg_type_mem))
      else $error("debug command with undefined type %h", dbg_cmd.cmd_type);

endmodule

// File: design/ib_slot_ctl.sv
// ------------------------------------------------------------
// slot occupancy and write/shift select generation
// lane i0 needs slot 3 free, lane i1 needs slot 2 free
// flush is registered, valids clear one cycle after that
// ------------------------------------------------------------
`timescale 1ns/1ps

module ib_slot_ctl
   import ib_pkg::*;
(
   input  logic                clk,
   input  logic                rst_n,
   input  logic                fetch_i0_valid,
   input  logic                fetch_i1_valid,
   input  logic                decode_i0,
   input  logic                decode_i1,
   input  logic                flush,
   input  logic                dbg_take,
   output logic [ib_depth-1:0] ib_valid,
   output ib_wsel_t            wsel
);

   logic                flush_q;
   logic [ib_depth-1:0] val_q;
   logic [ib_depth-1:0] val_sh;    // occupancy after this cycle's retire
   logic [ib_depth-1:0] val_in;
   logic                i0_ok;
   logic                i1_ok;
   logic                shift1;
   logic                shift2;
   logic [ib_depth-1:0] i0_wen;
   logic [ib_depth-1:1] i1_wen;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         flush_q <= 1'b0;
      end else begin
         flush_q <= flush;
      end
   end

   // only take a lane if there is room for it
   assign i0_ok = fetch_i0_valid & ~val_q[ib_depth-1] & ~flush_q;
   assign i1_ok = fetch_i1_valid & ~val_q[ib_depth-2] & ~flush_q;

   assign shift1 = decode_i0 & ~decode_i1;
   assign shift2 = decode_i0 &  decode_i1;

   always_comb begin
      if (shift2) begin
         val_sh = {2'b00, val_q[ib_depth-1:2]};
      end else if (shift1) begin
         val_sh = {1'b0, val_q[ib_depth-1:1]};
      end else begin
         val_sh = val_q;
      end
   end

   // new entries land just above the shifted occupancy
   always_comb begin
      i0_wen[0] = ~val_sh[0] & (i0_ok | dbg_take);
      for (int k = 1; k < ib_depth; k++) begin
         i0_wen[k] = val_sh[k-1] & ~val_sh[k] & i0_ok;
      end
      i1_wen[1] = ~val_sh[0] & i1_ok;   // i0 went into slot 0
      for (int k = 2; k < ib_depth; k++) begin
         i1_wen[k] = val_sh[k-2] & ~val_sh[k-1] & i1_ok;
      end
   end

   assign val_in = (val_sh | i0_wen | {i1_wen, 1'b0}) & ~{ib_depth{flush_q}};

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         val_q <= '0;
      end else begin
         val_q <= val_in;
      end
   end

   assign ib_valid = val_q;

   always_comb begin
      wsel.i0_wen = i0_wen;
      wsel.i1_wen = i1_wen;
      wsel.sh_1_0 = shift1 & val_q[1];
      wsel.sh_2_1 = shift1 & val_q[2];
      wsel.sh_3_2 = shift1 & val_q[3];
      wsel.sh_2_0 = shift2 & val_q[2];
      wsel.sh_3_1 = shift2 & val_q[3];
      wsel.dbg_0  = ~val_sh[0] & dbg_take;   // debug word wins slot 0
   end

   // occupied slots form a run starting at slot 0
   a_valid_contig: assert property (@(posedge clk) disable iff (!rst_n)
      (val_q & (val_q + 1'b1)) == '0)
      else $error("ib valid vector has a hole: %b", val_q);

   a_dec_pair: assert property (@(posedge clk) disable iff (!rst_n)
      decode_i1 |-> decode_i0)
      else $error("decode_i1 without decode_i0");

   a_dec_valid: assert property (@(posedge clk) disable iff (!rst_n)
      !(decode_i0 && !val_q[0]) && !(decode_i1 && !val_q[1]))
      else $error("decode of an empty slot, valid %b", val_q);

endmodule

// File: design/ib_entry_array.sv
// ------------------------------------------------------------
// four entry payload registers with load and shift muxes
// selects from the slot control are one-hot per slot
// ------------------------------------------------------------
`timescale 1ns/1ps

module ib_entry_array
   import ib_pkg::*;
(
   input  logic            clk,
   input  ib_entry_t       fetch_i0,
   input  ib_entry_t       fetch_i1,
   input  logic [xlen-1:0] dbg_instr,
   input  ib_wsel_t        wsel,
   output ib_entry_t       dec_i0,
   output ib_entry_t       dec_i1
);

   ib_entry_t           slot_q  [ib_depth];
   ib_entry_t           slot_in [ib_depth];
   logic [ib_depth-1:0] slot_en;
   ib_entry_t           i0_entry;   // lane 0, or the debug word for slot 0

   // debug keeps lane 0 pc and fault fields, only the word changes
   always_comb begin
      i0_entry = fetch_i0;
      if (wsel.dbg_0) begin
         i0_entry.instr = dbg_instr;
      end
   end

   // load enables, a slot changes only when written or shifted into
   assign slot_en[3] = wsel.i0_wen[3] | wsel.i1_wen[3];
   assign slot_en[2] = wsel.i0_wen[2] | wsel.i1_wen[2] | wsel.sh_3_2;
   assign slot_en[1] = wsel.i0_wen[1] | wsel.i1_wen[1] | wsel.sh_2_1 | wsel.sh_3_1;
   assign slot_en[0] = wsel.i0_wen[0] | wsel.sh_1_0 | wsel.sh_2_0;

   always_comb begin
      slot_in[3] = wsel.i1_wen[3] ? fetch_i1 : fetch_i0;

      if (wsel.sh_3_2) begin
         slot_in[2] = slot_q[3];
      end else if (wsel.i1_wen[2]) begin
         slot_in[2] = fetch_i1;
      end else begin
         slot_in[2] = fetch_i0;
      end

      if (wsel.sh_2_1) begin
         slot_in[1] = slot_q[2];
      end else if (wsel.sh_3_1) begin
         slot_in[1] = slot_q[3];
      end else if (wsel.i1_wen[1]) begin
         slot_in[1] = fetch_i1;
      end else begin
         slot_in[1] = fetch_i0;
      end

      if (wsel.sh_1_0) begin
         slot_in[0] = slot_q[1];
      end else if (wsel.sh_2_0) begin
         slot_in[0] = slot_q[2];
      end else begin
         slot_in[0] = i0_entry;   // fetch lane 0 or debug
      end
   end

   always_ff @(posedge clk) begin
      for (int k = 0; k < ib_depth; k++) begin
         if (slot_en[k]) begin
            slot_q[k] <= slot_in[k];
         end
      end
   end

   assign dec_i0 = slot_q[0];
   assign dec_i1 = slot_q[1];

endmodule

// File: design/ib_top.sv
// ------------------------------------------------------------
// decode instruction buffer, two-wide fetch and decode
// no accept output: fetch watches ib_valid and re-presents
// decode_i1 is legal only with decode_i0
// ------------------------------------------------------------
`timescale 1ns/1ps

module ib_top
   import ib_pkg::*;
(
   input  logic                clk,
   input  logic                rst_n,

   input  ib_entry_t           fetch_i0,        // oldest fetch lane
   input  ib_entry_t           fetch_i1,
   input  logic                fetch_i0_valid,
   input  logic                fetch_i1_valid,

   input  logic                decode_i0,       // retire slot 0
   input  logic                decode_i1,       // also retire slot 1
   input  logic                flush,

   input  dbg_cmd_t            dbg_cmd,

   output logic [ib_depth-1:0] ib_valid,
   output ib_entry_t           dec_i0,
   output ib_entry_t           dec_i1,
   output logic                dbg_wdata_rs1,   // debug write data goes on rs1
   output logic                dbg_fence
);

   logic            dbg_take;
   logic [xlen-1:0] dbg_instr;
   ib_wsel_t        wsel;

   // debug command decode and the two registered flags
   ib_dbg_synth u_dbg_synth (
      .clk           (clk),
      .rst_n         (rst_n),
      .dbg_cmd       (dbg_cmd),
      .dbg_take      (dbg_take),
      .dbg_instr     (dbg_instr),
      .dbg_wdata_rs1 (dbg_wdata_rs1),
      .dbg_fence     (dbg_fence)
   );

   ib_slot_ctl u_slot_ctl (
      .clk            (clk),
      .rst_n          (rst_n),
      .fetch_i0_valid (fetch_i0_valid),
      .fetch_i1_valid (fetch_i1_valid),
      .decode_i0      (decode_i0),
      .decode_i1      (decode_i1),
      .flush          (flush),
      .dbg_take       (dbg_take),
      .ib_valid       (ib_valid),
      .wsel           (wsel)
   );

   // payload registers, slots 0 and 1 face decode
   ib_entry_array u_entry_array (
      .clk       (clk),
      .fetch_i0  (fetch_i0),
      .fetch_i1  (fetch_i1),
      .dbg_instr (dbg_instr),
      .wsel      (wsel),
      .dec_i0    (dec_i0),
      .dec_i1    (dec_i1)
   );

endmodule

// File: bench/ib_tb.sv
// ------------------------------------------------------------
// testbench for the decode instruction buffer
// stimulus and expected debug words come from bench/ib_stim.txt
// lane i1 is only offered together with lane i0
// ------------------------------------------------------------
`timescale 1ns/1ps

module ib_tb
   import ib_pkg::*;
();

   localparam int rst_cycles  = 8;
   localparam int drain_limit = 12;   // cycles before a drain gives up

   logic                clk;
   logic                rst_n;
   ib_entry_t           fetch_i0;
   ib_entry_t           fetch_i1;
   logic                fetch_i0_valid;
   logic                fetch_i1_valid;
   logic                decode_i0;
   logic                decode_i1;
   logic                flush;
   dbg_cmd_t            dbg_cmd;
   logic [ib_depth-1:0] ib_valid;
   ib_entry_t           dec_i0;
   ib_entry_t           dec_i1;
   logic                dbg_wdata_rs1;
   logic                dbg_fence;

   ib_entry_t mq[$];     // buffer model, oldest entry first
   logic      flush_m;   // registered flush as the model sees it
   int        checks;
   int        errors;

   ib_top dut0 (
      .clk            (clk),
      .rst_n          (rst_n),
      .fetch_i0       (fetch_i0),
      .fetch_i1       (fetch_i1),
      .fetch_i0_valid (fetch_i0_valid),
      .fetch_i1_valid (fetch_i1_valid),
      .decode_i0      (decode_i0),
      .decode_i1      (decode_i1),
      .flush          (flush),
      .dbg_cmd        (dbg_cmd),
      .ib_valid       (ib_valid),
      .dec_i0         (dec_i0),
      .dec_i1         (dec_i1),
      .dbg_wdata_rs1  (dbg_wdata_rs1),
      .dbg_fence      (dbg_fence)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;   // 8 ns period
   end

   task automatic check(input string name, input logic [$bits(ib_entry_t)-1:0] got,
                        input logic [$bits(ib_entry_t)-1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR %s at %0t: got %h, expected %h", name, $time, got, exp);
      end
   endtask

   // pc4 and fault bits are not in the file
   function automatic ib_entry_t make_entry(input logic [31:0] word,
                                            input logic [31:0] pc_byte);
      ib_entry_t   e;
      logic [31:0] r;
      r       = $urandom;
      e.instr = word;
      e.pc    = pc_byte[31:1];
      e.pc4   = r[0];
      e.fault = r[5:1];
      return e;
   endfunction

   task automatic drive_idle();
      fetch_i0       = '0;
      fetch_i1       = '0;
      fetch_i0_valid = 1'b0;
      fetch_i1_valid = 1'b0;
      decode_i0      = 1'b0;
      decode_i1      = 1'b0;
      flush          = 1'b0;
      dbg_cmd        = '0;
   endtask

   // next buffer state from the acceptance, shift and flush rules
   task automatic model_step(input logic v0, input ib_entry_t e0, input logic v1,
                             input ib_entry_t e1, input logic d0, input logic d1,
                             input dbg_cmd_t cmd, input logic [xlen-1:0] dbg_word);
      int        pre;
      logic      ok0;
      logic      ok1;
      logic      take;
      ib_entry_t de;
      pre  = mq.size();
      ok0  = v0 && (pre < ib_depth) && !flush_m;       // slot 3 free
      ok1  = v1 && (pre < ib_depth - 1) && !flush_m;   // slot 2 free
      take = cmd.valid && (cmd.cmd_type != dbg_type_mem);
      if (d0) begin
         de = mq.pop_front();
      end
      if (d1) begin
         de = mq.pop_front();
      end
      if (ok0) begin
         mq.push_back(e0);
      end else if (take && mq.size() == 0) begin
         de       = e0;        // lane 0 pc and faults ride along
         de.instr = dbg_word;
         mq.push_back(de);
      end
      if (ok1) begin
         mq.push_back(e1);
      end
      if (flush_m) begin
         mq.delete();
      end
   endtask

   task automatic compare_outputs(input logic exp_wd, input logic exp_fe);
      logic [ib_depth-1:0] exp_valid;
      exp_valid = (1 << mq.size()) - 1;
      check("ib_valid", ib_valid, exp_valid);
      if (mq.size() > 0) begin
         check("dec_i0", dec_i0, mq[0]);
      end
      if (mq.size() > 1) begin
         check("dec_i1", dec_i1, mq[1]);
      end
      check("dbg_wdata_rs1", dbg_wdata_rs1, exp_wd);
      check("dbg_fence", dbg_fence, exp_fe);
   endtask

   // called 1 ns after a rising edge, returns 1 ns after the next one
   task automatic step_cycle(input logic v0, input ib_entry_t e0, input logic v1,
                             input ib_entry_t e1, input logic d0, input logic d1,
                             input logic fl, input dbg_cmd_t cmd,
                             input logic [xlen-1:0] dbg_word,
                             input logic exp_wd, input logic exp_fe);
      fetch_i0_valid = v0;
      fetch_i0       = e0;
      fetch_i1_valid = v1;
      fetch_i1       = e1;
      decode_i0      = d0;
      decode_i1      = d1;
      flush          = fl;
      dbg_cmd        = cmd;
      model_step(v0, e0, v1, e1, d0, d1, cmd, dbg_word);
      flush_m = fl;
      @(posedge clk);
      #1;
      compare_outputs(exp_wd, exp_fe);
   endtask

   task automatic drain_buffer();
      int n;
      n = 0;
      while (ib_valid != '0 && n < drain_limit) begin
         step_cycle(1'b0, '0, 1'b0, '0, mq.size() > 0, mq.size() > 1, 1'b0, '0,
                    '0, 1'b0, 1'b0);
         n++;
      end
      if (ib_valid != '0) begin
         errors++;
         $display("timeout: buffer still holds entries after %0d drain cycles", n);
      end
   endtask

   task automatic apply_reset();
      rst_n = 1'b0;
      drive_idle();
      repeat (rst_cycles) @(posedge clk);
      #1;
      rst_n = 1'b1;
      mq.delete();
      flush_m = 1'b0;
      compare_outputs(1'b0, 1'b0);   // empty, no debug flags
   endtask

   initial begin
      int unsigned seed;
      int          fd;
      int          rc;
      int          op;
      int          err_mark;
      string       line;
      logic [31:0] v0, i0w, pc0;
      logic [31:0] v1, i1w, pc1;
      logic [31:0] d0, d1, fl;
      logic [31:0] dv, dw, dt, da;
      logic [31:0] ei, ewd, efe;
      ib_entry_t   e0;
      ib_entry_t   e1;
      dbg_cmd_t    cmd;
      seed     = $urandom(99182);
      checks   = 0;
      errors   = 0;
      err_mark = 0;
      drive_idle();
      apply_reset();
      fd = $fopen("bench/ib_stim.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("could not open the stimulus file bench/ib_stim.txt");
      end else begin
         while (!$feof(fd)) begin
            line = "";
            rc   = $fgets(line, fd);
            if (rc > 0 && line.len() > 1 && line.getc(0) != "#") begin
               rc = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            op, v0, i0w, pc0, v1, i1w, pc1, d0, d1, fl,
                            dv, dw, dt, da, ei, ewd, efe);
               case (op)
                  0: begin
                     e0  = make_entry(i0w, pc0);
                     e1  = make_entry(i1w, pc1);
                     cmd = {dv[0], dw[0], dt[1:0], da[11:0]};
                     step_cycle(v0[0], e0, v1[0], e1, d0[0], d1[0], fl[0], cmd, ei,
                                ewd[0], efe[0]);
                  end
                  1: drain_buffer();
                  2: apply_reset();
                  3: begin
                     // second column holds the test number here
                     $display("test %0d finished with %0d errors", v0, errors - err_mark);
                     err_mark = errors;
                  end
                  default: begin
                     errors++;
                     $display("unknown op %0d in the stimulus file", op);
                  end
               endcase
            end
         end
         $fclose(fd);
      end
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// File: bench/ib_stim.txt
# op v0 instr0 pc0 v1 instr1 pc1 d0 d1 fl dv dw dt addr exp_instr exp_wd exp_fe
# op 0 one cycle, 1 drain, 2 reset, 3 end of test n; all fields hex
# test 1: two-wide fill, refused lanes not stored
0 1 a0000001 00001000 1 a0000002 00001004 0 0 0 0 0 0 000 00000000 0 0
0 1 a0000003 00001008 0 a0000004 0000100c 0 0 0 0 0 0 000 00000000 0 0
0 1 a0000005 0000100c 1 a0000006 00001010 0 0 0 0 0 0 000 00000000 0 0
0 1 a0000007 00001014 1 a0000008 00001018 0 0 0 0 0 0 000 00000000 0 0
0 0 00000000 00000000 0 00000000 00000000 0 0 0 0 0 0 000 00000000 0 0
3 1
# test 2: retire one or two with fetch in the same cycle
0 1 b0000001 00002000 1 b0000002 00002004 1 1 0 0 0 0 000 00000000 0 0
0 1 b0000003 00002008 1 b0000004 0000200c 1 0 0 0 0 0 000 00000000 0 0
0 1 b0000005 00002010 1 b0000006 00002014 1 1 0 0 0 0 000 00000000 0 0
0 1 b0000007 00002018 0 b0000008 0000201c 1 0 0 0 0 0 000 00000000 0 0
0 1 b0000009 00002020 1 b000000a 00002024 1 1 0 0 0 0 000 00000000 0 0
0 0 00000000 00000000 0 00000000 00000000 0 0 0 0 0 0 000 00000000 0 0
1
3 2
# test 3: flush, fetch dropped in the registered-flush cycle
0 1 c0000001 00003000 1 c0000002 00003004 0 0 0 0 0 0 000 00000000 0 0
0 1 c0000003 00003008 1 c0000004 0000300c 0 0 1 0 0 0 000 00000000 0 0
0 1 c0000005 00003010 1 c0000006 00003014 0 0 0 0 0 0 000 00000000 0 0
0 1 c0000007 00003018 1 c0000008 0000301c 0 0 0 0 0 0 000 00000000 0 0
0 0 00000000 00000000 0 00000000 00000000 0 0 1 0 0 0 000 00000000 0 0
0 0 00000000 00000000 0 00000000 00000000 0 0 0 0 0 0 000 00000000 0 0
3 3
# test 4: debug gpr and csr commands, last one finds slot 0 busy
0 0 00000000 00004000 0 00000000 00000000 0 0 0 1 0 0 0e5 0002e033 0 0
0 0 00000000 00004004 0 00000000 00000000 1 0 0 1 1 0 00a 00006533 1 0
0 0 00000000 00004008 0 00000000 00000000 1 0 0 1 0 1 300 30002073 0 0
0 0 00000000 0000400c 0 00000000 00000000 1 0 0 1 1 1 341 34101073 1 0
0 0 00000000 00004010 0 00000000 00000000 0 0 0 1 0 0 0e5 0002e033 0 0
0 0 00000000 00004014 0 00000000 00000000 1 0 0 0 0 0 000 00000000 0 0
3 4
# test 5: debug fence, then a memory command that is ignored
0 0 00000000 00005000 0 00000000 00000000 0 0 0 1 1 1 7c4 7c401073 1 1
0 0 00000000 00005004 0 00000000 00000000 1 0 0 0 0 0 000 00000000 0 0
0 0 00000000 00005008 0 00000000 00000000 0 0 0 1 1 2 7c4 00000000 0 0
0 0 00000000 0000500c 0 00000000 00000000 0 0 0 0 0 0 000 00000000 0 0
3 5
# test 6: reset with a full buffer
0 1 d0000001 00006000 1 d0000002 00006004 0 0 0 0 0 0 000 00000000 0 0
0 1 d0000003 00006008 1 d0000004 0000600c 0 0 0 0 0 0 000 00000000 0 0
2
3 6

// File: files.f
design/ib_pkg.sv
design/ib_dbg_synth.sv
design/ib_slot_ctl.sv
design/ib_entry_array.sv
design/ib_top.sv
bench/ib_tb.sv
